// File: design/rx_core_pkg.sv
// shared widths, sample and stream words, register map and compat number of the rx core, used by scoped name
package rx_core_pkg;

   //////////////////////////////
   // widths that carry a meaning
   typedef logic signed [11:0] sample_t;     // adc or corrected I/Q component
   typedef logic [31:0]        stime_t;      // sample time
   typedef logic [1:0]         chan_id_t;    // up to 4 channels
   typedef logic [7:0]         decim_t;      // keep one sample of every decim+1
   typedef logic [7:0]         axil_addr_t;  // axi byte address
   typedef logic [31:0]        reg_word_t;   // register data word

   typedef struct packed {
      stime_t  stime;   // counter value when the adc values were on the ports
      sample_t i;
      sample_t q;
   } iq_sample_t;

   typedef struct packed {
      chan_id_t   chan;
      iq_sample_t iq;
   } rx_word_t;

   // settings bus, one strobe per register write
   typedef struct packed {
      logic       stb;
      logic [7:0] addr;   // word address
      reg_word_t  data;
   } set_bus_t;

   //////////////////////////////
   // register map, byte addresses
   localparam axil_addr_t REG_DC_I      = 8'h00;
   localparam axil_addr_t REG_DC_Q      = 8'h04;
   localparam axil_addr_t REG_TIME      = 8'h08;
   localparam axil_addr_t REG_COMPAT    = 8'h0C;
   localparam axil_addr_t REG_CHAN_BASE = 8'h10;
   localparam int CHAN_STRIDE     = 8;
   localparam int CHAN_STATUS_OFS = 4;   // status sits behind the control word

   localparam reg_word_t COMPAT_NUM  = 32'd6;
   localparam reg_word_t RB_UNMAPPED = 32'h0000_BEEF;

   // the settings bus carries word addresses
   function automatic logic [7:0] word_addr(axil_addr_t byte_addr);
      return {2'b00, byte_addr[7:2]};
   endfunction

   function automatic axil_addr_t chan_ctrl_addr(int n);
      return axil_addr_t'(int'(REG_CHAN_BASE) + CHAN_STRIDE * n);
   endfunction

   function automatic axil_addr_t chan_status_addr(int n);
      return axil_addr_t'(int'(chan_ctrl_addr(n)) + CHAN_STATUS_OFS);
   endfunction

endpackage

// File: design/axil_settings.sv
// axi4-lite slave of the rx core; writes become settings-bus strobes, reads return time, compat and status
`timescale 1ns/1ps

module axil_settings #(
   parameter int NUM_CHANNELS = 2
) (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   // write address and data channels
   input  rx_core_pkg::axil_addr_t s_awaddr_i,
   input  logic                    s_awvalid_i,
   output logic                    s_awready_o,
   input  rx_core_pkg::reg_word_t  s_wdata_i,
   input  logic                    s_wvalid_i,
   output logic                    s_wready_o,
   // write response
   output logic [1:0]              s_bresp_o,
   output logic                    s_bvalid_o,
   input  logic                    s_bready_i,
   // read address and data
   input  rx_core_pkg::axil_addr_t s_araddr_i,
   input  logic                    s_arvalid_i,
   output logic                    s_arready_o,
   output rx_core_pkg::reg_word_t  s_rdata_o,
   output logic [1:0]              s_rresp_o,
   output logic                    s_rvalid_o,
   input  logic                    s_rready_i,
   // settings bus and readback sources
   output rx_core_pkg::set_bus_t   set_bus_o,
   input  rx_core_pkg::stime_t     cur_time_i,
   input  logic [NUM_CHANNELS-1:0] overrun_i
);

   logic                   wr_take;
   logic                   rd_take;
   logic                   set_stb;
   logic [7:0]             set_addr;
   rx_core_pkg::reg_word_t set_data;
   rx_core_pkg::reg_word_t rb_word;

   //////////////////////////////
   // write path
   // address and data are taken together, one write in flight
   assign wr_take     = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
   assign s_awready_o = wr_take;
   assign s_wready_o  = wr_take;
   assign s_bresp_o   = 2'b00;   // OKAY

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         s_bvalid_o <= 1'b0;
         set_stb    <= 1'b0;
      end
      else
      begin
         set_stb <= wr_take;   // single cycle, same edge as bvalid
         if (wr_take)
            s_bvalid_o <= 1'b1;
         else if (s_bready_i)
            s_bvalid_o <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_take)
      begin
         set_addr <= rx_core_pkg::word_addr(s_awaddr_i);
         set_data <= s_wdata_i;
      end
   end

   assign set_bus_o = '{stb: set_stb, addr: set_addr, data: set_data};

   //////////////////////////////
   // read path
   assign s_arready_o = !s_rvalid_o;
   assign rd_take     = s_arvalid_i && s_arready_o;
   assign s_rresp_o   = 2'b00;   // OKAY

   // readback mux, anything not listed returns the unmapped marker
   always_comb
   begin
      rb_word = rx_core_pkg::RB_UNMAPPED;
      if (s_araddr_i == rx_core_pkg::REG_TIME)
         rb_word = cur_time_i;
      else if (s_araddr_i == rx_core_pkg::REG_COMPAT)
         rb_word = rx_core_pkg::COMPAT_NUM;
      for (int n = 0; n < NUM_CHANNELS; n++)
      begin
         if (s_araddr_i == rx_core_pkg::chan_status_addr(n))
            rb_word = {31'd0, overrun_i[n]};   // sticky overrun in bit 0
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         s_rvalid_o <= 1'b0;
      else if (rd_take)
         s_rvalid_o <= 1'b1;
      else if (s_rready_i)
         s_rvalid_o <= 1'b0;
   end

   // data is sampled at the address handshake and held with rvalid
   always_ff @(posedge wb_clk)
   begin
      if (rd_take)
         s_rdata_o <= rb_word;
   end

endmodule

// File: design/rx_frontend.sv
// rx front end; removes the dc offset from each adc sample, saturates it and stamps it with the sample time
`timescale 1ns/1ps

module rx_frontend (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  rx_core_pkg::set_bus_t   set_bus_i,
   input  rx_core_pkg::sample_t    adc_i_i,
   input  rx_core_pkg::sample_t    adc_q_i,
   output rx_core_pkg::iq_sample_t sample_o,
   output rx_core_pkg::stime_t     cur_time_o
);

   logic                 hit_dc_i;
   logic                 hit_dc_q;
   logic                 hit_time;
   rx_core_pkg::sample_t dc_i;
   rx_core_pkg::sample_t dc_q;
   rx_core_pkg::stime_t  time_cnt;
   logic signed [12:0]   diff_i;   // one guard bit
   logic signed [12:0]   diff_q;

   // clip a 13 bit difference into +2047 / -2048
   function automatic rx_core_pkg::sample_t saturate(input logic signed [12:0] d);
      if (d[12] != d[11])
         return d[12] ? 12'sh800 : 12'sh7FF;
      return d[11:0];
   endfunction

   assign hit_dc_i = set_bus_i.stb && set_bus_i.addr == rx_core_pkg::word_addr(rx_core_pkg::REG_DC_I);
   assign hit_dc_q = set_bus_i.stb && set_bus_i.addr == rx_core_pkg::word_addr(rx_core_pkg::REG_DC_Q);
   assign hit_time = set_bus_i.stb && set_bus_i.addr == rx_core_pkg::word_addr(rx_core_pkg::REG_TIME);

   // offsets and the loadable time counter
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         dc_i     <= '0;
         dc_q     <= '0;
         time_cnt <= '0;
      end
      else
      begin
         if (hit_dc_i)
            dc_i <= set_bus_i.data[11:0];
         if (hit_dc_q)
            dc_q <= set_bus_i.data[11:0];
         if (hit_time)
            time_cnt <= set_bus_i.data;   // visible the cycle after stb
         else
            time_cnt <= time_cnt + 1'b1;
      end
   end

   assign diff_i = $signed({adc_i_i[11], adc_i_i}) - $signed({dc_i[11], dc_i});
   assign diff_q = $signed({adc_q_i[11], adc_q_i}) - $signed({dc_q[11], dc_q});

   // one cycle latency, time is that of the cycle the adc values arrived
   always_ff @(posedge wb_clk)
   begin
      sample_o.stime <= time_cnt;
      sample_o.i     <= saturate(diff_i);
      sample_o.q     <= saturate(diff_q);
   end

   assign cur_time_o = time_cnt;

endmodule

// File: design/rx_channel.sv
// one receive channel; enable and decimation register, sample FIFO towards the stream mux, sticky overrun
`timescale 1ns/1ps

module rx_channel #(
   parameter int CHAN       = 0,
   parameter int FIFO_DEPTH = 8   // power of two, at least 2
) (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  rx_core_pkg::set_bus_t   set_bus_i,
   input  rx_core_pkg::iq_sample_t sample_i,
   output rx_core_pkg::rx_word_t   word_o,
   output logic                    avail_o,
   input  logic                    pop_i,
   output logic                    overrun_o
);

   localparam int PTR_W = $clog2(FIFO_DEPTH);

   logic                  ctrl_hit;
   logic                  enable;
   rx_core_pkg::decim_t   decim;
   rx_core_pkg::decim_t   dec_cnt;
   logic                  keep;
   logic                  full;
   logic                  push;
   logic [PTR_W:0]        wr_ptr;   // msb is the wrap bit
   logic [PTR_W:0]        rd_ptr;
   rx_core_pkg::rx_word_t mem [FIFO_DEPTH];

   assign ctrl_hit = set_bus_i.stb &&
                     set_bus_i.addr == rx_core_pkg::word_addr(rx_core_pkg::chan_ctrl_addr(CHAN));

   //////////////////////////////
   // enable and decimation
   assign keep = enable && (dec_cnt == '0);

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         enable  <= 1'b0;
         decim   <= '0;
         dec_cnt <= '0;
      end
      else if (ctrl_hit)
      begin
         enable  <= set_bus_i.data[0];
         decim   <= set_bus_i.data[15:8];
         dec_cnt <= '0;   // first sample after the write is kept
      end
      else if (enable)
      begin
         if (dec_cnt == decim)
            dec_cnt <= '0;
         else
            dec_cnt <= dec_cnt + 1'b1;
      end
   end

   //////////////////////////////
   // sample fifo
   assign full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                    (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
   assign push    = keep && !full;
   assign avail_o = (wr_ptr != rd_ptr);
   assign word_o  = mem[rd_ptr[PTR_W-1:0]];   // head of the fifo

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i && avail_o)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (push)
         mem[wr_ptr[PTR_W-1:0]] <= '{chan: rx_core_pkg::chan_id_t'(CHAN), iq: sample_i};
   end

   // a kept sample that finds the fifo full is dropped
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         overrun_o <= 1'b0;
      else if (ctrl_hit && !set_bus_i.data[0])
         overrun_o <= 1'b0;   // disable write clears it
      else if (keep && full)
         overrun_o <= 1'b1;
   end

endmodule

// File: design/rx_stream_mux.sv
// round-robin merge of the channel FIFOs into one valid/ready stream through a registered output slot
`timescale 1ns/1ps

module rx_stream_mux #(
   parameter int NUM_CHANNELS = 2
) (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  rx_core_pkg::rx_word_t   word_i [NUM_CHANNELS],
   input  logic [NUM_CHANNELS-1:0] avail_i,
   output logic [NUM_CHANNELS-1:0] pop_o,
   output rx_core_pkg::rx_word_t   rx_word_o,
   output logic                    rx_valid_o,
   input  logic                    rx_ready_i
);

   logic                    slot_free;
   logic                    found;
   rx_core_pkg::chan_id_t   last_gnt;
   rx_core_pkg::chan_id_t   gnt;
   logic [NUM_CHANNELS-1:0] gnt_oh;
   rx_core_pkg::rx_word_t   gnt_word;

   assign slot_free = !rx_valid_o || rx_ready_i;   // empty or being taken

   // pass 0 looks above the last grant, pass 1 wraps around
   always_comb
   begin
      found    = 1'b0;
      gnt      = last_gnt;
      gnt_oh   = '0;
      gnt_word = word_i[0];
      for (int p = 0; p < 2; p++)
      begin
         for (int j = 0; j < NUM_CHANNELS; j++)
         begin
            if (!found && avail_i[j] && ((p == 0) == (j > int'(last_gnt))))
            begin
               found     = 1'b1;
               gnt       = rx_core_pkg::chan_id_t'(j);
               gnt_oh[j] = 1'b1;
               gnt_word  = word_i[j];
            end
         end
      end
   end

   assign pop_o = slot_free ? gnt_oh : '0;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         rx_valid_o <= 1'b0;
         last_gnt   <= '0;
      end
      else if (slot_free)
      begin
         rx_valid_o <= found;
         if (found)
            last_gnt <= gnt;
      end
   end

   // slot holds its word until the consumer takes it
   always_ff @(posedge wb_clk)
   begin
      if (slot_free && found)
         rx_word_o <= gnt_word;
   end

endmodule

// File: design/rx_core_top.sv
// top of the rx core; axi4-lite settings slave, dc front end, generated channels and the output stream mux
`timescale 1ns/1ps

module rx_core_top #(
   parameter int NUM_CHANNELS = 2,   // 1..4
   parameter int FIFO_DEPTH   = 8
) (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   // axi4-lite slave
   input  rx_core_pkg::axil_addr_t s_awaddr_i,
   input  logic                    s_awvalid_i,
   output logic                    s_awready_o,
   input  rx_core_pkg::reg_word_t  s_wdata_i,
   input  logic                    s_wvalid_i,
   output logic                    s_wready_o,
   output logic [1:0]              s_bresp_o,
   output logic                    s_bvalid_o,
   input  logic                    s_bready_i,
   input  rx_core_pkg::axil_addr_t s_araddr_i,
   input  logic                    s_arvalid_i,
   output logic                    s_arready_o,
   output rx_core_pkg::reg_word_t  s_rdata_o,
   output logic [1:0]              s_rresp_o,
   output logic                    s_rvalid_o,
   input  logic                    s_rready_i,
   // adc samples, one per clock
   input  rx_core_pkg::sample_t    adc_i_i,
   input  rx_core_pkg::sample_t    adc_q_i,
   // output stream
   output rx_core_pkg::rx_word_t   rx_word_o,
   output logic                    rx_valid_o,
   input  logic                    rx_ready_i
);

   rx_core_pkg::set_bus_t   set_bus;
   rx_core_pkg::iq_sample_t fe_sample;
   rx_core_pkg::stime_t     cur_time;
   rx_core_pkg::rx_word_t   chan_word [NUM_CHANNELS];
   logic [NUM_CHANNELS-1:0] chan_avail;
   logic [NUM_CHANNELS-1:0] chan_pop;
   logic [NUM_CHANNELS-1:0] chan_overrun;

   //////////////////////////////
   // settings and front end
   axil_settings #(.NUM_CHANNELS(NUM_CHANNELS)) axil_settings_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .s_awaddr_i(s_awaddr_i), .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o),
      .s_wdata_i(s_wdata_i), .s_wvalid_i(s_wvalid_i), .s_wready_o(s_wready_o),
      .s_bresp_o(s_bresp_o), .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i),
      .s_araddr_i(s_araddr_i), .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o),
      .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o), .s_rvalid_o(s_rvalid_o),
      .s_rready_i(s_rready_i),
      .set_bus_o(set_bus), .cur_time_i(cur_time), .overrun_i(chan_overrun));

   rx_frontend rx_frontend_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_bus_i(set_bus),
      .adc_i_i(adc_i_i), .adc_q_i(adc_q_i),
      .sample_o(fe_sample), .cur_time_o(cur_time));

   //////////////////////////////
   // receive channels
   for (genvar n = 0; n < NUM_CHANNELS; n++)
   begin : g_chan
      rx_channel #(.CHAN(n), .FIFO_DEPTH(FIFO_DEPTH)) rx_channel_inst (
         .wb_clk(wb_clk), .wb_rst(wb_rst), .set_bus_i(set_bus), .sample_i(fe_sample),
         .word_o(chan_word[n]), .avail_o(chan_avail[n]), .pop_i(chan_pop[n]),
         .overrun_o(chan_overrun[n]));
   end

   rx_stream_mux #(.NUM_CHANNELS(NUM_CHANNELS)) rx_stream_mux_inst (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .word_i(chan_word), .avail_i(chan_avail), .pop_o(chan_pop),
      .rx_word_o(rx_word_o), .rx_valid_o(rx_valid_o), .rx_ready_i(rx_ready_i));

endmodule

// File: tb/rx_core_assertions.sv
// handshake and reset checks bound into the rx core top level
`timescale 1ns/1ps

module rx_core_assertions (
   input logic                  wb_clk,
   input logic                  wb_rst,
   input logic                  bvalid_i,
   input logic                  bready_i,
   input logic                  rvalid_i,
   input logic                  rready_i,
   input rx_core_pkg::rx_word_t word_i,
   input logic                  valid_i,
   input logic                  ready_i
);

   int fail_count = 0;   // failed assertions so far

   //////////////////////////////
   // axi responses hold until taken
   bvalid_hold: assert property (@(posedge wb_clk) disable iff (wb_rst)
      bvalid_i && !bready_i |=> bvalid_i)
   else
   begin
      fail_count++;
      $error("bvalid dropped before bready");
   end

   rvalid_hold: assert property (@(posedge wb_clk) disable iff (wb_rst)
      rvalid_i && !rready_i |=> rvalid_i)
   else
   begin
      fail_count++;
      $error("rvalid dropped before rready");
   end

   // output slot frozen under back-pressure
   word_hold: assert property (@(posedge wb_clk) disable iff (wb_rst)
      valid_i && !ready_i |=> valid_i && $stable(word_i))
   else
   begin
      fail_count++;
      $error("stream word changed while stalled");
   end

   valid_after_reset: assert property (@(posedge wb_clk) wb_rst |=> !valid_i)
   else
   begin
      fail_count++;
      $error("stream valid high after reset");
   end

endmodule

bind rx_core_top rx_core_assertions rx_core_assertions_inst (
   .wb_clk(wb_clk), .wb_rst(wb_rst),
   .bvalid_i(s_bvalid_o), .bready_i(s_bready_i),
   .rvalid_i(s_rvalid_o), .rready_i(s_rready_i),
   .word_i(rx_word_o), .valid_i(rx_valid_o), .ready_i(rx_ready_i));

// File: tb/rx_core_tb.sv
// testbench for the rx core; AXI-Lite setup, table of offset rows, stream checks and overrun test
`timescale 1ns/1ps

module rx_core_tb;

   localparam int NUM_CH       = 2;
   localparam int FIFO_DEPTH   = 8;
   localparam int AXI_TIMEOUT  = 50;     // cycles per handshake wait
   localparam int RUN_TIMEOUT  = 2000;
   localparam int WORDS_PER_CH = 6;
   localparam int TIME_BOUND   = 100;
   localparam logic [7:0]  CH0_CTRL   = 8'h10;
   localparam logic [7:0]  CH0_STATUS = 8'h14;
   localparam logic [7:0]  CH1_CTRL   = 8'h18;
   localparam logic [7:0]  CH1_STATUS = 8'h1C;
   localparam logic [31:0] TIME_LOAD  = 32'h0001_0000;

   typedef struct packed {
      rx_core_pkg::sample_t off_i;
      rx_core_pkg::sample_t off_q;
      rx_core_pkg::sample_t adc_i;
      rx_core_pkg::sample_t adc_q;
      rx_core_pkg::decim_t  decim0;
      rx_core_pkg::decim_t  decim1;
      logic [1:0]           en_mask;   // bit n enables channel n
      rx_core_pkg::sample_t exp_i;
      rx_core_pkg::sample_t exp_q;
   } stim_row_t;

   // expected values are adc minus offset, clipped to 2047 / -2048
   stim_row_t stim_table [5] = '{
      '{12'sd0, 12'sd0, 12'sd100, -12'sd200, 8'd2, 8'd3, 2'b11, 12'sd100, -12'sd200},
      '{12'sd50, -12'sd30, 12'sd1000, -12'sd1000, 8'd1, 8'd0, 2'b01, 12'sd950, -12'sd970},
      '{-12'sd1000, 12'sd500, 12'sd1500, -12'sd1800, 8'd4, 8'd2, 2'b11, 12'sd2047, 12'sh800},
      '{12'sd2047, 12'sh800, 12'sh800, 12'sd2047, 8'd5, 8'd1, 2'b10, 12'sh800, 12'sd2047},
      '{-12'sd1, 12'sd1, 12'sd2046, -12'sd2047, 8'd2, 8'd2, 2'b11, 12'sd2047, 12'sh800}
   };

   logic                    wb_clk = 1'b0;
   logic                    wb_rst;
   rx_core_pkg::axil_addr_t s_awaddr_i;
   logic                    s_awvalid_i;
   logic                    s_awready_o;
   rx_core_pkg::reg_word_t  s_wdata_i;
   logic                    s_wvalid_i;
   logic                    s_wready_o;
   logic [1:0]              s_bresp_o;
   logic                    s_bvalid_o;
   logic                    s_bready_i;
   rx_core_pkg::axil_addr_t s_araddr_i;
   logic                    s_arvalid_i;
   logic                    s_arready_o;
   rx_core_pkg::reg_word_t  s_rdata_o;
   logic [1:0]              s_rresp_o;
   logic                    s_rvalid_o;
   logic                    s_rready_i;
   rx_core_pkg::sample_t    adc_i_i;
   rx_core_pkg::sample_t    adc_q_i;
   rx_core_pkg::rx_word_t   rx_word_o;
   logic                    rx_valid_o;
   logic                    rx_ready_i;
   integer                  seed;

   always #10 wb_clk = ~wb_clk;   // 20 ns period

   rx_core_top #(.NUM_CHANNELS(NUM_CH), .FIFO_DEPTH(FIFO_DEPTH)) rx_core_top_inst (.*);

   //////////////////////////////
   // reporting
   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string what, input logic [31:0] got_v,
                              input logic [31:0] exp_v);
      if (got_v !== exp_v)
      begin
         $display("mismatch at time %0t: %s, got %0h expected %0h", $time, what, got_v, exp_v);
         stop_with_failure("run stopped at the first error");
      end
   endtask

   // one clock edge of a bounded wait
   task automatic step_clock(inout int cycles, input int limit, input string what);
      @(posedge wb_clk);
      cycles++;
      if (cycles > limit)
         stop_with_failure(what);
   endtask

   function automatic logic [31:0] ctrl_word(input logic en, input rx_core_pkg::decim_t decim);
      return {16'd0, decim, 7'd0, en};
   endfunction

   //////////////////////////////
   // AXI-Lite master
   task automatic axi_write(input rx_core_pkg::axil_addr_t addr,
                            input rx_core_pkg::reg_word_t data);
      int cycles;
      cycles = 0;
      @(posedge wb_clk);
      s_awaddr_i  <= addr;
      s_awvalid_i <= 1'b1;
      s_wdata_i   <= data;
      s_wvalid_i  <= 1'b1;
      do
         step_clock(cycles, AXI_TIMEOUT, "timeout waiting for awready and wready");
      while (!(s_awready_o && s_wready_o));
      s_awvalid_i <= 1'b0;
      s_wvalid_i  <= 1'b0;
      cycles = 0;
      do
         step_clock(cycles, AXI_TIMEOUT, "timeout waiting for bvalid");
      while (!s_bvalid_o);
      check_value("write response", 32'(s_bresp_o), 32'd0);   // OKAY
      s_bready_i <= 1'b1;   // response taken one cycle late
      @(posedge wb_clk);
      s_bready_i <= 1'b0;
   endtask

   task automatic axi_read(input rx_core_pkg::axil_addr_t addr,
                           output rx_core_pkg::reg_word_t data);
      int cycles;
      cycles = 0;
      @(posedge wb_clk);
      s_araddr_i  <= addr;
      s_arvalid_i <= 1'b1;
      do
         step_clock(cycles, AXI_TIMEOUT, "timeout waiting for arready");
      while (!s_arready_o);
      s_arvalid_i <= 1'b0;
      cycles = 0;
      do
         step_clock(cycles, AXI_TIMEOUT, "timeout waiting for rvalid");
      while (!s_rvalid_o);
      data = s_rdata_o;
      check_value("read response", 32'(s_rresp_o), 32'd0);   // OKAY
      s_rready_i <= 1'b1;   // data taken one cycle late
      @(posedge wb_clk);
      s_rready_i <= 1'b0;
   endtask

   //////////////////////////////
   // stream side
   task automatic apply_row(input stim_row_t row);
      @(posedge wb_clk);
      rx_ready_i <= 1'b0;   // hold the stream while the channels start
      adc_i_i    <= row.adc_i;
      adc_q_i    <= row.adc_q;
      axi_write(8'h00, 32'(row.off_i));
      axi_write(8'h04, 32'(row.off_q));
      axi_write(CH0_CTRL, ctrl_word(row.en_mask[0], row.decim0));
      axi_write(CH1_CTRL, ctrl_word(row.en_mask[1], row.decim1));
   endtask

   task automatic collect_words(input stim_row_t row);
      int                    got [NUM_CH];
      rx_core_pkg::stime_t   last_time [NUM_CH];
      rx_core_pkg::rx_word_t w;
      int                    cycles;
      int                    c;
      for (int n = 0; n < NUM_CH; n++)
         got[n] = 0;
      cycles = 0;
      while ((row.en_mask[0] && got[0] < WORDS_PER_CH) ||
             (row.en_mask[1] && got[1] < WORDS_PER_CH))
      begin
         step_clock(cycles, RUN_TIMEOUT, "timeout waiting for words of every enabled channel");
         if (rx_valid_o && rx_ready_i)
         begin
            w = rx_word_o;
            c = int'(w.chan);
            check_value("chan in range", 32'(c < NUM_CH), 32'd1);
            check_value("chan enabled", 32'(row.en_mask[c]), 32'd1);
            check_value("corrected i", 32'(w.iq.i), 32'(row.exp_i));
            check_value("corrected q", 32'(w.iq.q), 32'(row.exp_q));
            if (got[c] > 0)   // spacing of kept samples is decim+1
               check_value($sformatf("time step ch%0d", c), w.iq.stime - last_time[c],
                           32'(c == 0 ? row.decim0 : row.decim1) + 32'd1);
            last_time[c] = w.iq.stime;
            got[c]++;
         end
         rx_ready_i <= (($random(seed) & 3) != 0);   // ready about 3 of 4 cycles
      end
      rx_ready_i <= 1'b0;
   endtask

   task automatic drain_stream();
      int idle;
      int cycles;
      idle   = 0;
      cycles = 0;
      @(posedge wb_clk);
      rx_ready_i <= 1'b1;
      while (idle < 4)
      begin
         step_clock(cycles, RUN_TIMEOUT, "timeout while draining the stream");
         idle = rx_valid_o ? 0 : idle + 1;
      end
   endtask

   task automatic wait_for_word(input logic [1:0] chan);
      int cycles;
      cycles = 0;
      do
         step_clock(cycles, RUN_TIMEOUT, "stream did not resume after back-pressure");
      while (!(rx_valid_o && rx_ready_i));
      check_value("resumed chan", 32'(rx_word_o.chan), 32'(chan));
   endtask

   initial
   begin
      rx_core_pkg::reg_word_t rd;
      seed        = 32'hdf2cec15;
      wb_rst      = 1'b1;
      s_awaddr_i  = '0;
      s_awvalid_i = 1'b0;
      s_wdata_i   = '0;
      s_wvalid_i  = 1'b0;
      s_bready_i  = 1'b0;
      s_araddr_i  = '0;
      s_arvalid_i = 1'b0;
      s_rready_i  = 1'b0;
      adc_i_i     = '0;
      adc_q_i     = '0;
      rx_ready_i  = 1'b0;
      repeat (3) @(posedge wb_clk);
      wb_rst <= 1'b0;

      // readback of compat, unmapped space and the time counter
      axi_read(8'h0C, rd);
      check_value("compat number", rd, 32'd6);
      axi_read(8'h40, rd);
      check_value("unmapped read", rd, 32'h0000_BEEF);
      axi_write(8'h08, TIME_LOAD);
      axi_read(8'h08, rd);
      check_value("time after load", 32'(rd > TIME_LOAD && rd < TIME_LOAD + TIME_BOUND), 32'd1);

      for (int r = 0; r < 5; r++)
      begin
         apply_row(stim_table[r]);
         collect_words(stim_table[r]);
         axi_write(CH0_CTRL, 32'd0);
         axi_write(CH1_CTRL, 32'd0);
         drain_stream();
      end

      //////////////////////////////
      // back-pressure until channel 0 overflows
      @(posedge wb_clk);
      rx_ready_i <= 1'b0;
      axi_write(CH0_CTRL, ctrl_word(1'b1, 8'd1));
      repeat (FIFO_DEPTH * 2 + 20) @(posedge wb_clk);
      axi_read(CH0_STATUS, rd);
      check_value("ch0 overrun set", rd, 32'd1);
      axi_read(CH1_STATUS, rd);
      check_value("ch1 overrun clear", rd, 32'd0);
      @(posedge wb_clk);
      rx_ready_i <= 1'b1;
      wait_for_word(2'd0);
      axi_write(CH0_CTRL, 32'd0);   // disable clears the flag
      axi_read(CH0_STATUS, rd);
      check_value("ch0 overrun after disable", rd, 32'd0);
      drain_stream();

      if (rx_core_top_inst.rx_core_assertions_inst.fail_count == 0)
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
      else
         stop_with_failure("a bound assertion failed during the run");
   end

endmodule

// File: tb.f
design/rx_core_pkg.sv
design/axil_settings.sv
design/rx_frontend.sv
design/rx_channel.sv
design/rx_stream_mux.sv
design/rx_core_top.sv
tb/rx_core_assertions.sv
tb/rx_core_tb.sv

// File: run.sh
#!/bin/sh
# build the rx core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module rx_core_tb -f tb.f
out=$(./obj_dir/Vrx_core_tb 2>&1) || true
printf '%s\n' "$out"
# the run passes only if the pass message was printed
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"
